// ==== verilog/ipod_pkg.sv ====
`default_nettype none

package ipod_pkg;

  // ==========================================================
  // Bus and sample widths
  // ==========================================================

  // Flash word address
  localparam int FLASH_ADDR_W = 23;

  // One flash word holds two samples
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 16;

  // Top byte of a sample goes to the audio output
  localparam int AUDIO_W      = 8;

  // Sample-rate divisor in CLK_50M cycles
  localparam int DIVISOR_W    = 32;

  // ==========================================================
  // Keyboard commands and play direction
  // ==========================================================

  // Upper-case ASCII codes
  typedef enum logic [7:0] {
    CMD_PLAY     = 8'h45,
    CMD_PAUSE    = 8'h44,
    CMD_FORWARD  = 8'h46,
    CMD_BACKWARD = 8'h42,
    CMD_RESTART  = 8'h52
  } kbd_cmd_t;

  typedef enum logic {
    DIR_FORWARD  = 1'b0,
    DIR_BACKWARD = 1'b1
  } play_dir_t;

endpackage

`default_nettype wire

// ==== verilog/sample_fetch_if.sv ====
`default_nettype none

interface sample_fetch_if;
  import ipod_pkg::*;

  // One-cycle request for the word at addr
  logic                    req;
  logic [FLASH_ADDR_W-1:0] addr;

  // One-cycle completion, data valid in the same cycle
  logic                    done;
  logic [FLASH_DATA_W-1:0] data;

  modport requester (
    output req,
    output addr,
    input  done,
    input  data
  );

  modport server (
    input  req,
    input  addr,
    output done,
    output data
  );

endinterface

`default_nettype wire

// ==== verilog/command_decoder.sv ====
`default_nettype none

module command_decoder (
  input  wire                 CLK_50M,
  input  wire                 rst,
  input  wire  [7:0]          kbd_ascii,
  input  wire                 kbd_strobe,
  output logic                playing,
  output ipod_pkg::play_dir_t direction,
  output logic                restart
);
  import ipod_pkg::*;

  logic [7:0] upper_code;

  // Fold 'a'..'z' onto 'A'..'Z'
  always_comb
  begin
    if (kbd_ascii >= 8'h61 && kbd_ascii <= 8'h7A)
    begin
      upper_code = kbd_ascii - 8'h20;
    end
    else
    begin
      upper_code = kbd_ascii;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing   <= 1'b0;
      direction <= DIR_FORWARD;
      restart   <= 1'b0;
    end
    else
    begin
      // Restart is a single-cycle pulse
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (kbd_cmd_t'(upper_code))
          CMD_PLAY:     playing   <= 1'b1;
          CMD_PAUSE:    playing   <= 1'b0;
          CMD_FORWARD:  direction <= DIR_FORWARD;
          CMD_BACKWARD: direction <= DIR_BACKWARD;
          CMD_RESTART:  restart   <= 1'b1;
          // Any other key is ignored
          default:      ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sample_rate_gen.sv ====
`default_nettype none

module sample_rate_gen #(
  parameter logic [ipod_pkg::DIVISOR_W-1:0] DEFAULT_DIVISOR = 32'd1136,
  parameter logic [ipod_pkg::DIVISOR_W-1:0] DIVISOR_STEP    = 32'd64,
  parameter logic [ipod_pkg::DIVISOR_W-1:0] MIN_DIVISOR     = 32'd256,
  parameter int unsigned                    REPEAT_CYCLES   = 5_000_000
) (
  input  wire                             CLK_50M,
  input  wire                             rst,
  input  wire                             speed_up,
  input  wire                             speed_down,
  input  wire                             speed_reset,
  output logic [ipod_pkg::DIVISOR_W-1:0]  sample_divisor,
  output logic                            sample_tick
);
  import ipod_pkg::*;

  localparam int REPEAT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;

  logic [REPEAT_W-1:0]  repeat_cnt;
  logic                 repeat_wrap;
  logic [DIVISOR_W-1:0] divisor_next;
  logic                 divisor_change;
  logic [DIVISOR_W-1:0] tick_cnt;

  // ==========================================================
  // Repeat counter, idle while no step button is held
  // ==========================================================
  assign repeat_wrap = (repeat_cnt == REPEAT_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (rst || !(speed_up || speed_down) || repeat_wrap)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // Speed reset wins over the step buttons
  always_comb
  begin
    divisor_next = sample_divisor;
    if (speed_reset)
    begin
      divisor_next = DEFAULT_DIVISOR;
    end
    else if (repeat_wrap && speed_up)
    begin
      // Faster playback, clamped at the floor
      if (sample_divisor >= MIN_DIVISOR + DIVISOR_STEP)
        divisor_next = sample_divisor - DIVISOR_STEP;
      else
        divisor_next = MIN_DIVISOR;
    end
    else if (repeat_wrap && speed_down)
    begin
      if (sample_divisor <= {DIVISOR_W{1'b1}} - DIVISOR_STEP)
        divisor_next = sample_divisor + DIVISOR_STEP;
    end
  end

  assign divisor_change = (divisor_next != sample_divisor);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_divisor <= DEFAULT_DIVISOR;
    else
      sample_divisor <= divisor_next;
  end

  // ==========================================================
  // Tick counter, restarted on every divisor change
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst || divisor_change)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= sample_divisor - 1'b1)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sample_sequencer.sv ====
`default_nettype none

module sample_sequencer #(
  parameter logic [ipod_pkg::FLASH_ADDR_W-1:0] LAST_WORD_ADDR = 23'h7FFFF
) (
  input  wire                            CLK_50M,
  input  wire                            rst,
  input  wire                            playing,
  input  wire ipod_pkg::play_dir_t       direction,
  input  wire                            restart,
  input  wire                            sample_tick,
  sample_fetch_if.requester              fetch,
  output logic [ipod_pkg::AUDIO_W-1:0]   audio_data,
  output logic                           audio_strobe
);
  import ipod_pkg::*;

  // EMPTY needs a word, HALF holds a word with its second half pending
  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_FETCH,
    ST_DRAIN,
    ST_HALF
  } seq_state_t;

  seq_state_t              state;
  logic [FLASH_ADDR_W-1:0] word_addr;
  logic [FLASH_ADDR_W-1:0] next_addr;
  logic [FLASH_DATA_W-1:0] held_word;
  play_dir_t               word_dir;
  logic                    half_sel;
  logic                    first_half;
  logic                    fetch_busy;

  // Upper byte of the chosen 16-bit half
  function automatic logic [AUDIO_W-1:0] top_byte(input logic [FLASH_DATA_W-1:0] word,
                                                 input logic half);
    logic [SAMPLE_W-1:0] sample;
    sample = half ? word[FLASH_DATA_W-1:SAMPLE_W] : word[SAMPLE_W-1:0];
    return sample[SAMPLE_W-1 -: AUDIO_W];
  endfunction

  assign fetch.addr = word_addr;

  // Backward words start with the high half
  assign first_half = (word_dir == DIR_BACKWARD);
  assign fetch_busy = (state == ST_FETCH || state == ST_DRAIN) && !fetch.done;

  // Step uses the live direction, so a change lands on the word boundary
  always_comb
  begin
    if (direction == DIR_FORWARD)
      next_addr = (word_addr == LAST_WORD_ADDR) ? '0 : word_addr + 1'b1;
    else
      next_addr = (word_addr == '0) ? LAST_WORD_ADDR : word_addr - 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state        <= ST_EMPTY;
      word_addr    <= '0;
      word_dir     <= DIR_FORWARD;
      half_sel     <= 1'b0;
      fetch.req    <= 1'b0;
      audio_data   <= '0;
      audio_strobe <= 1'b0;
    end
    else
    begin
      fetch.req    <= 1'b0;
      audio_strobe <= 1'b0;
      if (restart)
      begin
        word_addr <= (direction == DIR_FORWARD) ? '0 : LAST_WORD_ADDR;
        word_dir  <= direction;
        // An outstanding read still has to finish, its word is dropped
        state     <= fetch_busy ? ST_DRAIN : ST_EMPTY;
      end
      else
      begin
        case (state)
          ST_EMPTY:
          begin
            if (sample_tick && playing)
            begin
              fetch.req <= 1'b1;
              state     <= ST_FETCH;
            end
          end
          ST_FETCH:
          begin
            if (fetch.done)
            begin
              audio_data   <= top_byte(fetch.data, first_half);
              audio_strobe <= 1'b1;
              half_sel     <= ~first_half;
              state        <= ST_HALF;
            end
          end
          ST_DRAIN:
          begin
            if (fetch.done)
              state <= ST_EMPTY;
          end
          ST_HALF:
          begin
            if (sample_tick && playing)
            begin
              audio_data   <= top_byte(held_word, half_sel);
              audio_strobe <= 1'b1;
              word_addr    <= next_addr;
              word_dir     <= direction;
              state        <= ST_EMPTY;
            end
          end
          default: state <= ST_EMPTY;
        endcase
      end
    end
  end

  // A drained word may land here too, HALF is only reached from FETCH
  always_ff @(posedge CLK_50M)
  begin
    if (fetch.done)
      held_word <= fetch.data;
  end

endmodule

`default_nettype wire

// ==== verilog/flash_reader.sv ====
`default_nettype none

module flash_reader (
  input  wire                                CLK_50M,
  input  wire                                rst,
  input  wire                                flash_waitrequest,
  input  wire  [ipod_pkg::FLASH_DATA_W-1:0]  flash_readdata,
  input  wire                                flash_readdatavalid,
  sample_fetch_if.server                     fetch,
  output logic                               flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0]  flash_address
);
  import ipod_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_WAIT
  } rd_state_t;

  rd_state_t state;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= RD_IDLE;
      flash_read    <= 1'b0;
      flash_address <= '0;
      fetch.done    <= 1'b0;
    end
    else
    begin
      fetch.done <= 1'b0;
      case (state)
        RD_IDLE:
        begin
          if (fetch.req)
          begin
            flash_address <= fetch.addr;
            flash_read    <= 1'b1;
            state         <= RD_REQ;
          end
        end
        // Hold read and address until the slave stops stalling
        RD_REQ:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= RD_WAIT;
          end
        end
        RD_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            fetch.done <= 1'b1;
            state      <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // Captured word goes out together with done
  always_ff @(posedge CLK_50M)
  begin
    if (state == RD_WAIT && flash_readdatavalid)
      fetch.data <= flash_readdata;
  end

endmodule

`default_nettype wire

// ==== verilog/ipod_top.sv ====
`default_nettype none

module ipod_top #(
  // 50 MHz / 1136 gives about 44 kHz
  parameter logic [ipod_pkg::DIVISOR_W-1:0]    DEFAULT_DIVISOR = 32'd1136,
  parameter logic [ipod_pkg::DIVISOR_W-1:0]    DIVISOR_STEP    = 32'd64,
  parameter logic [ipod_pkg::DIVISOR_W-1:0]    MIN_DIVISOR     = 32'd256,
  // Ten steps per second while a button is held
  parameter int unsigned                       REPEAT_CYCLES   = 5_000_000,
  parameter logic [ipod_pkg::FLASH_ADDR_W-1:0] LAST_WORD_ADDR  = 23'h7FFFF
) (
  input  wire                                CLK_50M,
  input  wire                                rst,

  // Keyboard
  input  wire  [7:0]                         kbd_ascii,
  input  wire                                kbd_strobe,

  // Speed buttons, active high levels
  input  wire                                speed_up,
  input  wire                                speed_down,
  input  wire                                speed_reset,

  // Flash read bus
  input  wire                                flash_waitrequest,
  input  wire  [ipod_pkg::FLASH_DATA_W-1:0]  flash_readdata,
  input  wire                                flash_readdatavalid,
  output logic                               flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0]  flash_address,

  // Audio and status
  output logic [ipod_pkg::AUDIO_W-1:0]       audio_data,
  output logic                               audio_strobe,
  output logic                               playing,
  output ipod_pkg::play_dir_t                direction,
  output logic [ipod_pkg::DIVISOR_W-1:0]     sample_divisor
);

  logic restart;
  logic sample_tick;

  sample_fetch_if fetch_bus ();

  // ==========================================================
  // Control path
  // ==========================================================
  command_decoder cmd_dec0 (
    .CLK_50M    (CLK_50M),
    .rst        (rst),
    .kbd_ascii  (kbd_ascii),
    .kbd_strobe (kbd_strobe),
    .playing    (playing),
    .direction  (direction),
    .restart    (restart)
  );

  sample_rate_gen #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .DIVISOR_STEP    (DIVISOR_STEP),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .REPEAT_CYCLES   (REPEAT_CYCLES)
  ) rate_gen0 (
    .CLK_50M        (CLK_50M),
    .rst            (rst),
    .speed_up       (speed_up),
    .speed_down     (speed_down),
    .speed_reset    (speed_reset),
    .sample_divisor (sample_divisor),
    .sample_tick    (sample_tick)
  );

  // ==========================================================
  // Sample path
  // ==========================================================
  sample_sequencer #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR)
  ) seq0 (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .playing      (playing),
    .direction    (direction),
    .restart      (restart),
    .sample_tick  (sample_tick),
    .fetch        (fetch_bus.requester),
    .audio_data   (audio_data),
    .audio_strobe (audio_strobe)
  );

  flash_reader reader0 (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .fetch               (fetch_bus.server),
    .flash_read          (flash_read),
    .flash_address       (flash_address)
  );

endmodule

`default_nettype wire

// ==== dv/flash_model.sv ====
`default_nettype none

module flash_model (
  input  wire                                CLK_50M,
  input  wire                                rst,
  input  wire                                flash_read,
  input  wire  [ipod_pkg::FLASH_ADDR_W-1:0]  flash_address,
  output logic                               flash_waitrequest,
  output logic [ipod_pkg::FLASH_DATA_W-1:0]  flash_readdata,
  output logic                               flash_readdatavalid
);
  timeunit 1ns;
  timeprecision 1ps;
  import ipod_pkg::*;

  integer                  seed;
  logic [31:0]             rnd;
  logic                    accepted;
  logic [FLASH_ADDR_W-1:0] accepted_addr;
  logic                    busy;
  logic [1:0]              delay;
  logic [FLASH_ADDR_W-1:0] read_addr;

  // Low half carries addr*2, high half addr*2+1, each in the upper byte
  function automatic logic [FLASH_DATA_W-1:0] word_at(input logic [FLASH_ADDR_W-1:0] addr);
    logic [7:0] low_byte;
    logic [7:0] high_byte;
    low_byte  = 8'(addr * 2);
    high_byte = 8'(addr * 2 + 1);
    return {high_byte, 8'h00, low_byte, 8'h00};
  endfunction

  initial
  begin
    seed                = 32'ha081_a076;
    accepted            = 1'b0;
    busy                = 1'b0;
    delay               = '0;
    read_addr           = '0;
    flash_waitrequest   = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  // A read is taken in a cycle with read high and waitrequest low
  always @(posedge CLK_50M)
  begin
    accepted      <= !rst && flash_read && !flash_waitrequest;
    accepted_addr <= flash_address;
  end

  // Bus outputs change on the falling edge only
  always @(negedge CLK_50M)
  begin
    rnd = $random(seed);
    flash_readdatavalid <= 1'b0;
    if (rst)
    begin
      busy = 1'b0;
      flash_waitrequest <= 1'b0;
    end
    else
    begin
      flash_waitrequest <= rnd[0];
      if (accepted)
      begin
        busy      = 1'b1;
        read_addr = accepted_addr;
        delay     = rnd[2:1];
      end
      // Zero to three extra cycles of read latency
      if (busy)
      begin
        if (delay == 0)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= word_at(read_addr);
          busy = 1'b0;
        end
        else
        begin
          delay = delay - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_ipod.sv ====
`default_nettype none

module tb_ipod;
  timeunit 1ns;
  timeprecision 1ps;
  import ipod_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int DEF_DIV      = 40;
  localparam int STEP         = 8;
  localparam int MIN_DIV      = 16;
  localparam int REPEAT       = 50;
  localparam int LAST_ADDR    = 5;
  localparam int DOWN_PERIODS = 3;
  localparam int UP_PERIODS   = 8;

  // Run budget from two tick periods per sample plus idle and speed phases
  localparam int PLAY_SAMPLES    = 33;
  localparam int IDLE_CYCLES     = 4 * DEF_DIV;
  localparam int SPEED_CYCLES    = (DOWN_PERIODS + UP_PERIODS + 3) * REPEAT;
  localparam int WATCHDOG_CYCLES = PLAY_SAMPLES * 2 * DEF_DIV + 3 * IDLE_CYCLES
                                   + SPEED_CYCLES + 1000;

  logic                    CLK_50M;
  logic                    rst;
  logic [7:0]              kbd_ascii;
  logic                    kbd_strobe;
  logic                    speed_up;
  logic                    speed_down;
  logic                    speed_reset;
  logic                    flash_waitrequest;
  logic [FLASH_DATA_W-1:0] flash_readdata;
  logic                    flash_readdatavalid;
  logic                    flash_read;
  logic [FLASH_ADDR_W-1:0] flash_address;
  logic [AUDIO_W-1:0]      audio_data;
  logic                    audio_strobe;
  logic                    playing;
  play_dir_t               direction;
  logic [DIVISOR_W-1:0]    sample_divisor;

  int checks       = 0;
  int value_errors = 0;
  int other_errors = 0;

  // Scoreboard state
  int         sb_addr;
  bit         sb_idx;
  play_dir_t  sb_dir;
  play_dir_t  tb_dir;
  int         strobe_count;
  int         cycle_count = 0;
  int         last_held_cycle;
  bit         held_seen;
  bit         half;
  logic [7:0] upper_key;
  int         count_before;

  ipod_top #(
    .DEFAULT_DIVISOR (DEF_DIV),
    .DIVISOR_STEP    (STEP),
    .MIN_DIVISOR     (MIN_DIV),
    .REPEAT_CYCLES   (REPEAT),
    .LAST_WORD_ADDR  (LAST_ADDR)
  ) dut0 (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .kbd_ascii           (kbd_ascii),
    .kbd_strobe          (kbd_strobe),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_data          (audio_data),
    .audio_strobe        (audio_strobe),
    .playing             (playing),
    .direction           (direction),
    .sample_divisor      (sample_divisor)
  );

  flash_model flash0 (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  // ============================================================
  // Protocol, reset and speed-reset properties
  // ============================================================
  assert property (@(posedge CLK_50M) disable iff (rst)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
  else
  begin
    value_errors++;
    $display("mismatch at %0t ns: flash read dropped or address moved under waitrequest", $time);
  end

  assert property (@(posedge CLK_50M)
    rst |=> !flash_read && !audio_strobe && audio_data == '0 && !playing
            && direction == DIR_FORWARD)
  else
  begin
    value_errors++;
    $display("mismatch at %0t ns: outputs not at reset values after rst", $time);
  end

  // Speed reset wins in every cycle including a repeat wrap
  assert property (@(posedge CLK_50M) disable iff (rst)
    speed_reset |=> sample_divisor == DEF_DIV)
  else
  begin
    value_errors++;
    $display("mismatch at %0t ns: divisor %0d after speed_reset, expected %0d",
             $time, sample_divisor, DEF_DIV);
  end

  // Sample value stored by the flash model for a word half
  function automatic logic [7:0] sample_value(input int addr, input bit hi);
    return 8'(addr * 2 + hi);
  endfunction

  // ============================================================
  // Scoreboard with the expected order from address and direction rules
  // ============================================================
  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (rst)
    begin
      sb_addr      = 0;
      sb_idx       = 1'b0;
      sb_dir       = DIR_FORWARD;
      tb_dir       = DIR_FORWARD;
      strobe_count = 0;
      held_seen    = 1'b0;
    end
    else
    begin
      if (audio_strobe)
      begin
        // Backward words play high half first
        half = (sb_dir == DIR_BACKWARD) ? !sb_idx : sb_idx;
        checks++;
        assert (audio_data == sample_value(sb_addr, half))
        else
        begin
          value_errors++;
          $display("mismatch at %0t ns: sample %0d is %0d, expected %0d (word %0d half %0d)",
                   $time, strobe_count, audio_data, sample_value(sb_addr, half),
                   sb_addr, half);
        end
        if (sb_idx)
        begin
          // Held-word samples land one cycle after every second tick
          if (held_seen)
          begin
            checks++;
            assert (cycle_count - last_held_cycle == 2 * DEF_DIV)
            else
            begin
              value_errors++;
              $display("mismatch at %0t ns: held samples %0d cycles apart, expected %0d",
                       $time, cycle_count - last_held_cycle, 2 * DEF_DIV);
            end
          end
          held_seen       = 1'b1;
          last_held_cycle = cycle_count;
          if (tb_dir == DIR_FORWARD)
            sb_addr = (sb_addr == LAST_ADDR) ? 0 : sb_addr + 1;
          else
            sb_addr = (sb_addr == 0) ? LAST_ADDR : sb_addr - 1;
          sb_dir = tb_dir;
          sb_idx = 1'b0;
        end
        else
        begin
          sb_idx = 1'b1;
        end
        strobe_count++;
      end
      if (kbd_strobe)
      begin
        upper_key = (kbd_ascii >= "a" && kbd_ascii <= "z") ? kbd_ascii - 8'h20 : kbd_ascii;
        held_seen = 1'b0;
        if (upper_key == CMD_BACKWARD)
          tb_dir = DIR_BACKWARD;
        else if (upper_key == CMD_FORWARD)
          tb_dir = DIR_FORWARD;
        else if (upper_key == CMD_RESTART)
        begin
          sb_addr = (tb_dir == DIR_FORWARD) ? 0 : LAST_ADDR;
          sb_dir  = tb_dir;
          sb_idx  = 1'b0;
        end
      end
    end
  end

  task automatic expect_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      value_errors++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  // One-cycle key strobe driven from a falling edge
  task automatic send_key(input logic [7:0] key);
    kbd_ascii  = key;
    kbd_strobe = 1'b1;
    @(negedge CLK_50M);
    kbd_strobe = 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int target;
    int waited;
    target = strobe_count + n;
    waited = 0;
    while (strobe_count < target && waited < n * 3 * DEF_DIV)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    if (strobe_count < target)
    begin
      other_errors++;
      $display("audio samples stopped at %0t ns, %0d of %0d arrived",
               $time, n - (target - strobe_count), n);
    end
  endtask

  task automatic pause_and_check();
    send_key("d");
    expect_value("playing after pause", playing, 1'b0);
    count_before = strobe_count;
    idle_cycles(IDLE_CYCLES);
    expect_value("samples while paused", strobe_count, count_before);
  endtask

  task automatic print_summary();
    $display("summary: %0d checks, %0d mismatches, %0d other errors",
             checks, value_errors, other_errors);
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    other_errors++;
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    print_summary();
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    CLK_50M     = 1'b0;
    rst         = 1'b1;
    kbd_ascii   = 8'h00;
    kbd_strobe  = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    idle_cycles(2);
    rst = 1'b0;
    @(negedge CLK_50M);

    // Reset state and silence before play
    expect_value("flash_read", flash_read, 1'b0);
    expect_value("flash_address", flash_address, 0);
    expect_value("audio_strobe", audio_strobe, 1'b0);
    expect_value("audio_data", audio_data, 0);
    expect_value("playing", playing, 1'b0);
    expect_value("direction", direction, DIR_FORWARD);
    expect_value("sample_divisor", sample_divisor, DEF_DIV);
    send_key("x");
    idle_cycles(IDLE_CYCLES);
    expect_value("samples before play", strobe_count, 0);

    // Forward through the wrap past the last word
    send_key("E");
    expect_value("playing after play", playing, 1'b1);
    wait_samples(16);
    pause_and_check();

    // Mid-word turn to backward, wrap, restart, then forward again
    send_key("e");
    wait_samples(1);
    send_key("B");
    expect_value("direction after B", direction, DIR_BACKWARD);
    wait_samples(8);
    send_key("r");
    wait_samples(4);
    send_key("F");
    expect_value("direction after F", direction, DIR_FORWARD);
    wait_samples(4);
    pause_and_check();

    // ============================================================
    // Divisor steps while paused
    // ============================================================
    speed_down = 1'b1;
    idle_cycles(DOWN_PERIODS * REPEAT + REPEAT / 2);
    speed_down = 1'b0;
    idle_cycles(2);
    expect_value("divisor after slow-down", sample_divisor, DEF_DIV + DOWN_PERIODS * STEP);

    speed_up = 1'b1;
    idle_cycles(UP_PERIODS * REPEAT + REPEAT / 2);
    speed_up = 1'b0;
    idle_cycles(2);
    expect_value("divisor after speed-up", sample_divisor,
                 (DEF_DIV + (DOWN_PERIODS - UP_PERIODS) * STEP < MIN_DIV) ? MIN_DIV
                 : DEF_DIV + (DOWN_PERIODS - UP_PERIODS) * STEP);

    speed_reset = 1'b1;
    @(negedge CLK_50M);
    speed_reset = 1'b0;
    expect_value("divisor after speed reset", sample_divisor, DEF_DIV);

    // Reset held against a step button
    speed_down  = 1'b1;
    speed_reset = 1'b1;
    idle_cycles(2 * REPEAT + REPEAT / 2);
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    idle_cycles(2);
    expect_value("divisor with reset held", sample_divisor, DEF_DIV);

    print_summary();
    if (value_errors == 0 && other_errors == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/ipod_pkg.sv
verilog/sample_fetch_if.sv
verilog/command_decoder.sv
verilog/sample_rate_gen.sv
verilog/sample_sequencer.sv
verilog/flash_reader.sv
verilog/ipod_top.sv
dv/flash_model.sv
dv/tb_ipod.sv
